// ==== hw/frame_rotator.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

module frame_rotator (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  imu_pkg::angle_t  angle,
    input  imu_pkg::sample_t ax,
    input  imu_pkg::sample_t ay,
    output logic             done,
    output imu_pkg::accum_t  wx,
    output imu_pkg::accum_t  wy
);

    imu_pkg::trig_t  cos_val;
    imu_pkg::trig_t  sin_val;
    imu_pkg::accum_t ax_cos;
    imu_pkg::accum_t ay_sin;
    imu_pkg::accum_t ax_sin;
    imu_pkg::accum_t ay_cos;
    logic            stage1;

    // Table lookup for the requested heading
    assign cos_val = imu_pkg::trig_cos(angle);
    assign sin_val = imu_pkg::trig_sin(angle);

    // Two-cycle sequence marker
    always_ff @(posedge clk) begin
        if (rst) begin
            stage1 <= 1'b0;
            done   <= 1'b0;
        end else begin
            stage1 <= start;
            done   <= stage1;
        end
    end

    // Stage one, the four products
    always_ff @(posedge clk) begin
        if (start) begin
            ax_cos <= ax * cos_val;
            ay_sin <= ay * sin_val;
            ax_sin <= ax * sin_val;
            ay_cos <= ay * cos_val;
        end
    end

    // Stage two, combine and drop the table scale
    always_ff @(posedge clk) begin
        if (stage1) begin
            wx <= (ax_cos - ay_sin) >>> `IMU_TRIG_SHIFT;
            wy <= (ax_sin + ay_cos) >>> `IMU_TRIG_SHIFT;
        end
    end

endmodule

// ==== hw/imu_dr_top.sv ====
`timescale 1ns/100ps

module imu_dr_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    output logic             sample_ready,
    input  imu_pkg::sample_t accel_x,
    input  imu_pkg::sample_t accel_y,
    input  imu_pkg::sample_t gyro_z,
    input  imu_pkg::dt_t     dt,
    output logic             result_valid,
    output imu_pkg::accum_t  theta,
    output imu_pkg::accum_t  vel_x,
    output imu_pkg::accum_t  vel_y,
    output imu_pkg::accum_t  pos_x,
    output imu_pkg::accum_t  pos_y
);

    // Producer to buffer, buffer to consumer
    wb_if wr_bus ();
    wb_if rd_bus ();

    sample_capture u_capture (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .accel_x      (accel_x),
        .accel_y      (accel_y),
        .gyro_z       (gyro_z),
        .dt           (dt),
        .wb           (wr_bus.master)
    );

    sample_fifo u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.slave),
        .rd  (rd_bus.slave)
    );

    nav_integrator u_integrator (
        .clk          (clk),
        .rst          (rst),
        .wb           (rd_bus.master),
        .result_valid (result_valid),
        .theta        (theta),
        .vel_x        (vel_x),
        .vel_y        (vel_y),
        .pos_x        (pos_x),
        .pos_y        (pos_y)
    );

endmodule

// ==== hw/imu_pkg.sv ====
`include "imu_macros.svh"

package imu_pkg;

    typedef logic signed [`IMU_SAMPLE_W-1:0]   sample_t;
    typedef logic        [`IMU_SAMPLE_W-1:0]   dt_t;
    typedef logic signed [`IMU_ACCUM_W-1:0]    accum_t;
    typedef logic        [`IMU_ANGLE_BITS-1:0] angle_t;
    typedef logic signed [`IMU_SAMPLE_W-1:0]   trig_t;
    typedef logic        [`IMU_FRAME_W-1:0]    frame_word_t;

    typedef enum logic [2:0] {
        nav_idle,
        nav_fetch,
        nav_rotate,
        nav_integ_vel,
        nav_integ_pos,
        nav_publish
    } nav_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Record packing

    function automatic frame_word_t pack_frame(input sample_t ax, input sample_t ay,
                                               input dt_t dt, input accum_t heading);
        return {ax, ay, dt, heading};
    endfunction

    function automatic void unpack_frame(input frame_word_t frame, output sample_t ax,
                                         output sample_t ay, output dt_t dt,
                                         output accum_t heading);
        {ax, ay, dt, heading} = frame;
    endfunction

    // Value times time step, back to accumulator scale
    function automatic accum_t dt_scale(input accum_t value, input dt_t dt);
        logic signed [`IMU_ACCUM_W+`IMU_SAMPLE_W:0] prod;
        prod = value * $signed({1'b0, dt});
        return accum_t'(prod >>> `IMU_DT_SHIFT);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Quarter-wave cosine, 16384 * cos(k * 2pi / 64) for k = 0..16

    localparam trig_t cos_quarter [`IMU_TRIG_ENTRIES] = '{
        16384, 16305, 16069, 15679, 15137, 14449, 13623, 12665, 11585,
        10394,  9102,  7723,  6270,  4756,  3196,  1606,     0
    };

    function automatic trig_t trig_cos(input angle_t angle);
        logic [1:0]  quad;
        int unsigned step;
        trig_t       value;
        quad = angle[`IMU_ANGLE_BITS-1 -: 2];
        step = angle[`IMU_ANGLE_BITS-3:0];
        case (quad)
            2'd0:    value = cos_quarter[step];
            2'd1:    value = -cos_quarter[`IMU_TRIG_ENTRIES - 1 - step];
            2'd2:    value = -cos_quarter[step];
            default: value = cos_quarter[`IMU_TRIG_ENTRIES - 1 - step];
        endcase
        return value;
    endfunction

    // sin(a) is cos(a - quarter turn)
    function automatic trig_t trig_sin(input angle_t angle);
        return trig_cos(angle_t'(angle - (1 << (`IMU_ANGLE_BITS - 2))));
    endfunction

endpackage

// ==== hw/nav_integrator.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

module nav_integrator (
    input  logic            clk,
    input  logic            rst,
    wb_if.master            wb,
    output logic            result_valid,
    output imu_pkg::accum_t theta,
    output imu_pkg::accum_t vel_x,
    output imu_pkg::accum_t vel_y,
    output imu_pkg::accum_t pos_x,
    output imu_pkg::accum_t pos_y
);

    imu_pkg::nav_state_t state;
    imu_pkg::sample_t    rec_ax;
    imu_pkg::sample_t    rec_ay;
    imu_pkg::dt_t        rec_dt;
    imu_pkg::accum_t     rec_heading;
    imu_pkg::dt_t        dt_q;
    imu_pkg::accum_t     heading_q;
    imu_pkg::accum_t     vel_acc_x;
    imu_pkg::accum_t     vel_acc_y;
    imu_pkg::accum_t     rot_x;
    imu_pkg::accum_t     rot_y;
    logic                rot_start;
    logic                rot_done;

    always_comb begin
        imu_pkg::unpack_frame(wb.dat, rec_ax, rec_ay, rec_dt, rec_heading);
    end

    // Read request held for the whole fetch state
    assign wb.cyc = (state == imu_pkg::nav_fetch);
    assign wb.stb = (state == imu_pkg::nav_fetch);
    assign wb.we  = 1'b0;

    // Rotation starts straight off the ack cycle data
    assign rot_start = (state == imu_pkg::nav_fetch) && wb.ack;

    frame_rotator u_rotator (
        .clk   (clk),
        .rst   (rst),
        .start (rot_start),
        .angle (rec_heading[`IMU_ACCUM_W-1 -: `IMU_ANGLE_BITS]),
        .ax    (rec_ax),
        .ay    (rec_ay),
        .done  (rot_done),
        .wx    (rot_x),
        .wy    (rot_y)
    );

    always_ff @(posedge clk) begin
        if (rot_start) begin
            dt_q      <= rec_dt;
            heading_q <= rec_heading;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer and accumulators

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= imu_pkg::nav_idle;
            result_valid <= 1'b0;
            vel_acc_x    <= '0;
            vel_acc_y    <= '0;
            theta        <= '0;
            vel_x        <= '0;
            vel_y        <= '0;
            pos_x        <= '0;
            pos_y        <= '0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                imu_pkg::nav_idle: begin
                    state <= imu_pkg::nav_fetch;
                end
                imu_pkg::nav_fetch: begin
                    if (wb.ack) begin
                        state <= imu_pkg::nav_rotate;
                    end
                end
                imu_pkg::nav_rotate: begin
                    state <= imu_pkg::nav_integ_vel;
                end
                // Waits here for the rotator result
                imu_pkg::nav_integ_vel: begin
                    if (rot_done) begin
                        vel_acc_x <= vel_acc_x + imu_pkg::dt_scale(rot_x, dt_q);
                        vel_acc_y <= vel_acc_y + imu_pkg::dt_scale(rot_y, dt_q);
                        state     <= imu_pkg::nav_integ_pos;
                    end
                end
                // Position uses the velocity just updated
                imu_pkg::nav_integ_pos: begin
                    pos_x        <= pos_x + imu_pkg::dt_scale(vel_acc_x, dt_q);
                    pos_y        <= pos_y + imu_pkg::dt_scale(vel_acc_y, dt_q);
                    vel_x        <= vel_acc_x;
                    vel_y        <= vel_acc_y;
                    theta        <= heading_q;
                    result_valid <= 1'b1;
                    state        <= imu_pkg::nav_publish;
                end
                imu_pkg::nav_publish: begin
                    state <= imu_pkg::nav_fetch;
                end
                default: begin
                    state <= imu_pkg::nav_idle;
                end
            endcase
        end
    end

endmodule

// ==== hw/sample_capture.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

module sample_capture (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    output logic             sample_ready,
    input  imu_pkg::sample_t accel_x,
    input  imu_pkg::sample_t accel_y,
    input  imu_pkg::sample_t gyro_z,
    input  imu_pkg::dt_t     dt,
    wb_if.master             wb
);

    imu_pkg::accum_t      heading;
    imu_pkg::accum_t      gyro_ext;
    imu_pkg::accum_t      heading_next;
    imu_pkg::frame_word_t record;
    logic                 pending;
    logic                 accept;

    // No new sample while a record waits for the buffer
    assign sample_ready = !pending;
    assign accept       = sample_valid && sample_ready;

    assign gyro_ext = {{(`IMU_ACCUM_W - `IMU_SAMPLE_W){gyro_z[`IMU_SAMPLE_W-1]}}, gyro_z};

    // Heading after this sample
    assign heading_next = heading + imu_pkg::dt_scale(gyro_ext, dt);

    ////////////////////////////////////////////////////////////////////////////
    // Heading integration and write request

    always_ff @(posedge clk) begin
        if (rst) begin
            heading <= '0;
            pending <= 1'b0;
        end else if (accept) begin
            heading <= heading_next;
            pending <= 1'b1;
        end else if (wb.ack) begin
            pending <= 1'b0;
        end
    end

    // Record stays steady until the buffer acks it
    always_ff @(posedge clk) begin
        if (accept) begin
            record <= imu_pkg::pack_frame(accel_x, accel_y, dt, heading_next);
        end
    end

    assign wb.cyc = pending;
    assign wb.stb = pending;
    assign wb.we  = 1'b1;
    assign wb.dat = record;

endmodule

// ==== hw/sample_fifo.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

module sample_fifo (
    input  logic clk,
    input  logic rst,
    wb_if.slave  wr,
    wb_if.slave  rd
);

    localparam int ptr_w = $clog2(`IMU_FIFO_DEPTH);

    imu_pkg::frame_word_t mem [`IMU_FIFO_DEPTH];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w:0]       count;
    logic                 wr_ack;
    logic                 rd_ack;
    logic                 full;
    logic                 empty;

    assign full  = (count == (ptr_w + 1)'(`IMU_FIFO_DEPTH));
    assign empty = (count == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Ack generation and pointers

    // One ack per request, the !ack term stops a repeat on the held stb
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ack <= wr.cyc && wr.stb && wr.we && !wr_ack && !full;
            rd_ack <= rd.cyc && rd.stb && !rd.we && !rd_ack && !empty;
            if (wr_ack) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ptr_w + 1)'(wr_ack) - (ptr_w + 1)'(rd_ack);
        end
    end

    // Store on the write ack cycle
    always_ff @(posedge clk) begin
        if (wr_ack) begin
            mem[wr_ptr] <= wr.dat;
        end
    end

    assign wr.ack = wr_ack;
    assign rd.ack = rd_ack;

    // Head record, valid during the read ack
    assign rd.dat = mem[rd_ptr];

endmodule

// ==== hw/wb_if.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

// Wishbone classic link carrying one record per transfer
interface wb_if;

    logic cyc;
    logic stb;
    logic we;
    logic ack;

    // Record word, driven by the master on writes and by the slave on reads
    wire [`IMU_FRAME_W-1:0] dat;

    modport master (
        output cyc,
        output stb,
        output we,
        input  ack,
        inout  dat
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        output ack,
        inout  dat
    );

endinterface

// ==== include/imu_macros.svh ====
`ifndef IMU_MACROS_SVH
`define IMU_MACROS_SVH

// Sensor word and accumulator widths
`define IMU_SAMPLE_W      16
`define IMU_ACCUM_W       32

// Record layout is ax, ay, dt, then the full heading
`define IMU_FRAME_W       (3 * `IMU_SAMPLE_W + `IMU_ACCUM_W)

// Records that can wait between producer and consumer
`define IMU_FIFO_DEPTH    4

// Heading bits used as table index, 64 steps per turn
`define IMU_ANGLE_BITS    6
`define IMU_TRIG_ENTRIES  ((1 << (`IMU_ANGLE_BITS - 2)) + 1)

// Fixed-point shifts
`define IMU_TRIG_SHIFT    14
`define IMU_DT_SHIFT      8

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the dead-reckoning testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module imu_dr_tb \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build step returned an error"
    exit 1
fi

./obj_dir/Vimu_dr_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+include
hw/imu_pkg.sv
hw/wb_if.sv
hw/sample_capture.sv
hw/sample_fifo.sv
hw/frame_rotator.sv
hw/nav_integrator.sv
hw/imu_dr_top.sv
tests/imu_dr_properties.sv
tests/imu_dr_tb.sv

// ==== tests/imu_dr_properties.sv ====
`timescale 1ns/100ps

module imu_dr_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 wr_stb,
    input logic                 wr_ack,
    input imu_pkg::frame_word_t wr_dat,
    input logic                 rd_stb,
    input logic                 rd_ack,
    input logic                 result_valid
);

    // Read by the testbench at the end of the run
    int unsigned failures = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone classic rules on both links

    wr_stb_held: assert property (@(posedge clk) disable iff (rst)
        wr_stb && !wr_ack |=> wr_stb)
        else begin
            failures++;
            $error("Write stb dropped before ack");
        end

    wr_dat_stable: assert property (@(posedge clk) disable iff (rst)
        wr_stb && !wr_ack |=> $stable(wr_dat))
        else begin
            failures++;
            $error("Write data changed while waiting for ack");
        end

    wr_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
        wr_ack |-> wr_stb)
        else begin
            failures++;
            $error("Write ack without stb");
        end

    wr_ack_single: assert property (@(posedge clk) disable iff (rst)
        wr_ack |=> !wr_ack)
        else begin
            failures++;
            $error("Write ack longer than one cycle");
        end

    rd_stb_held: assert property (@(posedge clk) disable iff (rst)
        rd_stb && !rd_ack |=> rd_stb)
        else begin
            failures++;
            $error("Read stb dropped before ack");
        end

    rd_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
        rd_ack |-> rd_stb)
        else begin
            failures++;
            $error("Read ack without stb");
        end

    rd_ack_single: assert property (@(posedge clk) disable iff (rst)
        rd_ack |=> !rd_ack)
        else begin
            failures++;
            $error("Read ack longer than one cycle");
        end

    // Result strobe is a single-cycle pulse
    result_pulse: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else begin
            failures++;
            $error("result_valid high for more than one cycle");
        end

endmodule

bind imu_dr_top imu_dr_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .wr_stb       (wr_bus.stb),
    .wr_ack       (wr_bus.ack),
    .wr_dat       (wr_bus.dat),
    .rd_stb       (rd_bus.stb),
    .rd_ack       (rd_bus.ack),
    .result_valid (result_valid)
);

// ==== tests/imu_dr_tb.sv ====
`timescale 1ns/100ps
`include "imu_macros.svh"

module imu_dr_tb;

    localparam int clk_period   = 10;
    localparam int random_count = 150;
    localparam int sweep_count  = 520;
    localparam int burst_count  = 200;
    localparam int total_count  = random_count + sweep_count + burst_count;
    // 20 cycles per sample at most, with a factor of two margin
    localparam longint watchdog_ns = longint'(total_count) * 20 * clk_period * 2;

    logic             clk;
    logic             rst;
    logic             sample_valid;
    logic             sample_ready;
    imu_pkg::sample_t accel_x;
    imu_pkg::sample_t accel_y;
    imu_pkg::sample_t gyro_z;
    imu_pkg::dt_t     dt;
    logic             result_valid;
    imu_pkg::accum_t  theta;
    imu_pkg::accum_t  vel_x;
    imu_pkg::accum_t  vel_y;
    imu_pkg::accum_t  pos_x;
    imu_pkg::accum_t  pos_y;

    integer     seed;
    string      test_name;
    int         checks;
    int         value_errors;
    int         other_errors;
    int         accepted;
    int         results;
    int         gap;
    logic [3:0] quadrants_seen;

    // Reference model state and expected results in acceptance order
    imu_pkg::accum_t m_heading;
    imu_pkg::accum_t m_vel_x;
    imu_pkg::accum_t m_vel_y;
    imu_pkg::accum_t m_pos_x;
    imu_pkg::accum_t m_pos_y;
    imu_pkg::accum_t exp_theta [$];
    imu_pkg::accum_t exp_vel_x [$];
    imu_pkg::accum_t exp_vel_y [$];
    imu_pkg::accum_t exp_pos_x [$];
    imu_pkg::accum_t exp_pos_y [$];

    imu_dr_top uut (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .accel_x      (accel_x),
        .accel_y      (accel_y),
        .gyro_z       (gyro_z),
        .dt           (dt),
        .result_valid (result_valid),
        .theta        (theta),
        .vel_x        (vel_x),
        .vel_y        (vel_y),
        .pos_x        (pos_x),
        .pos_y        (pos_y)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Product with the time step, then back to accumulator scale
    function automatic imu_pkg::accum_t times_dt(input imu_pkg::accum_t value,
                                                 input imu_pkg::dt_t step);
        longint step_ext;
        longint product;
        step_ext = {48'd0, step};
        product  = longint'(value) * step_ext;
        return imu_pkg::accum_t'(product >>> `IMU_DT_SHIFT);
    endfunction

    function automatic void rotate_pair(input imu_pkg::sample_t ax, input imu_pkg::sample_t ay,
                                        input imu_pkg::accum_t heading,
                                        output imu_pkg::accum_t wx, output imu_pkg::accum_t wy);
        imu_pkg::angle_t angle;
        longint          c;
        longint          s;
        angle = heading[`IMU_ACCUM_W-1 -: `IMU_ANGLE_BITS];
        c     = imu_pkg::trig_cos(angle);
        s     = imu_pkg::trig_sin(angle);
        wx    = imu_pkg::accum_t'((longint'(ax) * c - longint'(ay) * s) >>> `IMU_TRIG_SHIFT);
        wy    = imu_pkg::accum_t'((longint'(ax) * s + longint'(ay) * c) >>> `IMU_TRIG_SHIFT);
    endfunction

    function automatic void predict(input imu_pkg::sample_t ax, input imu_pkg::sample_t ay,
                                    input imu_pkg::sample_t gz, input imu_pkg::dt_t step);
        imu_pkg::accum_t wx;
        imu_pkg::accum_t wy;
        m_heading = m_heading + times_dt(imu_pkg::accum_t'(gz), step);
        rotate_pair(ax, ay, m_heading, wx, wy);
        m_vel_x = m_vel_x + times_dt(wx, step);
        m_vel_y = m_vel_y + times_dt(wy, step);
        m_pos_x = m_pos_x + times_dt(m_vel_x, step);
        m_pos_y = m_pos_y + times_dt(m_vel_y, step);
        exp_theta.push_back(m_heading);
        exp_vel_x.push_back(m_vel_x);
        exp_vel_y.push_back(m_vel_y);
        exp_pos_x.push_back(m_pos_x);
        exp_pos_y.push_back(m_pos_y);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_accum(input string field, input imu_pkg::accum_t expected,
                               input imu_pkg::accum_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, field, expected,
                     actual);
        end
    endtask

    task automatic check_angle(input string field, input imu_pkg::accum_t expected,
                               input imu_pkg::accum_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", test_name, field,
                     expected, actual);
        end
    endtask

    task automatic check_flag(input string field, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, field, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Holds the sample until the DUT takes it and updates the model after the accepting edge
    task automatic offer_sample(input imu_pkg::sample_t ax, input imu_pkg::sample_t ay,
                                input imu_pkg::sample_t gz, input imu_pkg::dt_t step);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            sample_valid = 1'b1;
            accel_x      = ax;
            accel_y      = ay;
            gyro_z       = gz;
            dt           = step;
            taken        = sample_ready;
        end
        @(posedge clk);
        accepted++;
        predict(ax, ay, gz, step);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            sample_valid = 1'b0;
        end
    endtask

    // Each result pulse is compared with the oldest prediction
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            results++;
            if (exp_theta.size() == 0) begin
                other_errors++;
                $display("Result pulse at %0t ns with no accepted sample behind it", $time);
            end else begin
                check_angle("theta", exp_theta.pop_front(), theta);
                check_accum("vel_x", exp_vel_x.pop_front(), vel_x);
                check_accum("vel_y", exp_vel_y.pop_front(), vel_y);
                check_accum("pos_x", exp_pos_x.pop_front(), pos_x);
                check_accum("pos_y", exp_pos_y.pop_front(), pos_y);
                quadrants_seen[theta[`IMU_ACCUM_W-1 -: 2]] = 1'b1;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, results stopped arriving after %0d of %0d samples",
                 results, accepted);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed           = 32'h4825621e;
        rst            = 1'b1;
        sample_valid   = 1'b0;
        accel_x        = '0;
        accel_y        = '0;
        gyro_z         = '0;
        dt             = '0;
        checks         = 0;
        value_errors   = 0;
        other_errors   = 0;
        accepted       = 0;
        results        = 0;
        quadrants_seen = '0;
        m_heading      = '0;
        m_vel_x        = '0;
        m_vel_y        = '0;
        m_pos_x        = '0;
        m_pos_y        = '0;
        test_name      = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_flag("sample_ready", 1'b1, sample_ready);
            check_flag("result_valid", 1'b0, result_valid);
            check_angle("theta", '0, theta);
            check_accum("vel_x", '0, vel_x);
            check_accum("vel_y", '0, vel_y);
            check_accum("pos_x", '0, pos_x);
            check_accum("pos_y", '0, pos_y);
        end

        // Full-range inputs with random gaps
        test_name = "random";
        repeat (random_count) begin
            offer_sample(imu_pkg::sample_t'($random(seed)), imu_pkg::sample_t'($random(seed)),
                         imu_pkg::sample_t'($random(seed)), imu_pkg::dt_t'($random(seed)));
            gap = $random(seed) & 3;
            idle_cycles(gap);
        end

        // Large positive yaw rate so the heading turns through every quadrant
        test_name = "sweep";
        repeat (sweep_count) begin
            offer_sample(imu_pkg::sample_t'($random(seed)), imu_pkg::sample_t'($random(seed)),
                         imu_pkg::sample_t'(16'h7000 | ($random(seed) & 16'h0fff)),
                         imu_pkg::dt_t'(16'hf000 | ($random(seed) & 16'h0fff)));
        end

        // Back to back offers keep the FIFO full
        test_name = "burst";
        repeat (burst_count) begin
            offer_sample(imu_pkg::sample_t'($random(seed)), imu_pkg::sample_t'($random(seed)),
                         imu_pkg::sample_t'($random(seed)), imu_pkg::dt_t'($random(seed)));
        end
        idle_cycles(1);

        wait (results == accepted);
        idle_cycles(20);

        test_name = "final";
        if (quadrants_seen != 4'hf) begin
            other_errors++;
            $display("Reported theta did not reach all four quadrants, seen mask %b",
                     quadrants_seen);
        end
        if (uut.u_props.failures != 0) begin
            other_errors++;
            $display("Protocol assertions failed %0d times", uut.u_props.failures);
        end

        $display("Samples %0d, results %0d, checks %0d, value errors %0d, other errors %0d",
                 accepted, results, checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
